// ==== project.f ====
verilog/uart_io_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_io.sv
tb/uart_io_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UART I/O testbench with Verilator, then judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f project.f --top-module uart_io_tb \
    -o uart_io_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/uart_io_sim 2>&1 | tee sim.log

grep -q "Finished with errors" sim.log \
    && { echo "Simulation FAILED"; exit 1; }

grep -q "Finished with no errors" sim.log \
    || { echo "Simulation ended without a result"; exit 1; }

echo "Simulation PASSED"
exit 0

// ==== tb/uart_io_tb.sv ====
// Testbench for the UART I/O port, running CPU accesses and serial frames from the tests file
`timescale 1ns/1ns
`default_nettype none

module uart_io_tb;

    import uart_io_pkg::*;

    localparam int    CLK_PERIOD    = 40;
    localparam int    DRIVE_DLY     = 5;
    localparam int    RESET_CYCLES  = 8;
    localparam int    SEED          = 36634;
    localparam int    FRAME_TIMEOUT = 20 * CLOCKS_PER_BIT;
    localparam int    POLL_LIMIT    = 200;
    localparam string TESTS_FILE    = "tb/uart_io_tests.txt";

    logic        Clock = 1'b0;
    logic        arst_n;
    logic [31:0] addr;
    logic [31:0] wr_data;
    logic        wr_en;
    logic        rd_en;
    logic [31:0] rd_data;
    logic        serial_in;
    logic        serial_out;

    // Frames seen on serial_out packed as {stop, data, start}
    logic [DATA_BITS+1:0] tx_frames[$];
    logic                 frame_active = 1'b0;

    always #(CLK_PERIOD / 2) Clock = ~Clock;

    uart_io dut_i (
        .Clock      (Clock),
        .arst_n     (arst_n),
        .addr       (addr),
        .wr_data    (wr_data),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .serial_in  (serial_in),
        .serial_out (serial_out)
    );

    // ------------------------------------------------------------
    // Failure reporting and checks
    // ------------------------------------------------------------
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
            fail_run($sformatf("MISMATCH at %0t ns: %s is 0x%08h, expected 0x%08h",
                               $time, name, got, expected));
    endtask

    // ------------------------------------------------------------
    // CPU bus and serial line drivers
    // ------------------------------------------------------------
    // Inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge Clock);
        #DRIVE_DLY;
    endtask

    task automatic write_reg(input logic [31:0] a, input logic [31:0] data);
        addr    = a;
        wr_data = data;
        wr_en   = 1'b1;
        next_cycle();
        wr_en   = 1'b0;
    endtask

    // rd_data is captured on the edge after the strobe
    task automatic read_reg(input logic [31:0] a, output logic [31:0] value);
        addr  = a;
        rd_en = 1'b1;
        next_cycle();
        rd_en = 1'b0;
        value = rd_data;
    endtask

    task automatic poll_status(input logic [31:0] mask);
        int          count;
        logic [31:0] word;
        count = 0;
        word  = '0;
        while ((word & mask) != mask && count < POLL_LIMIT)
        begin
            read_reg(STATUS_ADDR, word);
            count++;
        end
        if ((word & mask) != mask)
            fail_run($sformatf("Timeout polling status for bits 0x%0h", mask));
    endtask

    // 8N1 frame on serial_in with the LSB first
    task automatic send_frame(input logic [DATA_BITS-1:0] value);
        int i;
        serial_in = 1'b0;
        repeat (CLOCKS_PER_BIT) next_cycle();
        for (i = 0; i < DATA_BITS; i++)
        begin
            serial_in = value[i];
            repeat (CLOCKS_PER_BIT) next_cycle();
        end
        serial_in = 1'b1;
        repeat (CLOCKS_PER_BIT) next_cycle();
    endtask

    // ------------------------------------------------------------
    // Serial output monitor
    // ------------------------------------------------------------
    // Called at the first falling clock edge that sees the start bit
    task automatic capture_frame();
        logic [DATA_BITS-1:0] data;
        logic                 start_bit;
        logic                 stop_bit;
        int                   i;
        frame_active = 1'b1;
        repeat (HALF_BIT) @(negedge Clock);
        start_bit = serial_out;
        for (i = 0; i < DATA_BITS; i++)
        begin
            repeat (CLOCKS_PER_BIT) @(negedge Clock);
            data[i] = serial_out;
        end
        repeat (CLOCKS_PER_BIT) @(negedge Clock);
        stop_bit = serial_out;
        tx_frames.push_back({stop_bit, data, start_bit});
        frame_active = 1'b0;
    endtask

    initial
    begin
        forever
        begin
            @(negedge Clock);
            if (arst_n && !serial_out)
                capture_frame();
        end
    end

    task automatic expect_frame(input logic [DATA_BITS-1:0] expected);
        int                   count;
        logic [DATA_BITS+1:0] frame;
        count = 0;
        while (tx_frames.size() == 0 && count < FRAME_TIMEOUT)
        begin
            next_cycle();
            count++;
        end
        if (tx_frames.size() == 0)
            fail_run($sformatf("Timeout waiting for frame 0x%02h on serial_out", expected));
        else
        begin
            frame = tx_frames.pop_front();
            check_value("serial_out start bit", 32'(frame[0]), 32'd0);
            check_value("serial_out data", 32'(frame[DATA_BITS:1]), 32'(expected));
            check_value("serial_out stop bit", 32'(frame[DATA_BITS+1]), 32'd1);
        end
    endtask

    // ------------------------------------------------------------
    // Tests file interpreter
    // ------------------------------------------------------------
    task automatic run_line(input int fd, input logic [7:0] op);
        int          n;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] word;
        case (op)
            "W":
            begin
                n = $fscanf(fd, " %h %h", a, b);
                if (n != 2)
                    fail_run("Malformed W line in the tests file");
                else
                    write_reg(a, b);
            end
            "R":
            begin
                n = $fscanf(fd, " %h %h", a, b);
                if (n != 2)
                    fail_run("Malformed R line in the tests file");
                else
                begin
                    read_reg(a, word);
                    check_value($sformatf("rd_data from 0x%08h", a), word, b);
                end
            end
            "P", "S", "T":
            begin
                n = $fscanf(fd, " %h", a);
                if (n != 1)
                    fail_run($sformatf("Malformed %c line in the tests file", op));
                else if (op == "P")
                    poll_status(a);
                else if (op == "S")
                    send_frame(a[DATA_BITS-1:0]);
                else
                    expect_frame(a[DATA_BITS-1:0]);
            end
            default:
                fail_run($sformatf("Unknown operation %c in the tests file", op));
        endcase
    endtask

    initial
    begin
        int          fd;
        int          n;
        int          c;
        int          gap;
        int          i;
        logic [7:0]  op;
        logic [31:0] word;
        logic        at_end;

        arst_n    = 1'b0;
        addr      = '0;
        wr_data   = '0;
        wr_en     = 1'b0;
        rd_en     = 1'b0;
        serial_in = 1'b1;
        n = $urandom(SEED);

        repeat (RESET_CYCLES) @(posedge Clock);
        #DRIVE_DLY;
        arst_n = 1'b1;
        check_value("rd_data after reset", rd_data, 32'd0);

        // Line must idle high once out of reset
        for (i = 0; i < 2 * CLOCKS_PER_BIT; i++)
        begin
            next_cycle();
            check_value("serial_out after reset", 32'(serial_out), 32'd1);
        end
        read_reg(STATUS_ADDR, word);
        check_value("status after reset", word, 32'd1 << STAT_TX_READY);

        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0)
            fail_run("Could not open the tests file tb/uart_io_tests.txt");
        else
        begin
            at_end = 1'b0;
            while (!at_end)
            begin
                n = $fscanf(fd, " %c", op);
                if (n != 1)
                    at_end = 1'b1;
                else if (op == "#")
                begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1)
                        c = $fgetc(fd);
                end
                else
                begin
                    gap = int'($urandom % 3);
                    repeat (gap) next_cycle();
                    run_line(fd, op);
                end
            end
            $fclose(fd);

            // Room for a frame that nobody asked for
            repeat (12 * CLOCKS_PER_BIT) next_cycle();
            if (tx_frames.size() != 0 || frame_active)
                fail_run("An unexpected frame appeared on serial_out");
            else
            begin
                $display("Finished with no errors");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/uart_io_tests.txt ====
# Columns: op then hex operands. W addr data, R addr expected, P status mask,
# S byte driven on serial_in, T byte expected on serial_out. Status 80000000
# Reset state, tx ready only
R 80000000 00000001
# One byte out, tx ready low during the frame
W 80000008 000000A5
R 80000000 00000000
T A5
P 1
R 80000000 00000001
# Only the low byte of the write data is sent
W 80000008 12345681
T 81
P 1
# Write while busy is dropped
W 80000008 00000055
W 80000008 000000AA
T 55
P 1
W 80000008 0000003C
T 3C
P 1
# Receive one byte
S 5A
P 2
R 80000000 00000003
R 80000004 0000005A
R 80000000 00000001
# Two bytes without a read give overrun
S 11
S 22
P 4
R 80000000 00000007
R 80000004 00000022
R 80000000 00000001
# Writes elsewhere are ignored and unmapped reads return zero
W 80000000 FFFFFFFF
W 80000004 FFFFFFFF
R 80000000 00000001
R 80000010 00000000
R 00000000 00000000
R 8000000C 00000000
R FFFFFFFC 00000000

// ==== verilog/uart_io.sv ====
// Memory-mapped serial port with CPU register decode, receive holding register and read mux
`timescale 1ns/1ns
`default_nettype none

module uart_io (
    input  wire logic        Clock,
    input  wire logic        arst_n,
    input  wire logic [31:0] addr,
    input  wire logic [31:0] wr_data,
    input  wire logic        wr_en,
    input  wire logic        rd_en,
    output logic      [31:0] rd_data,
    input  wire logic        serial_in,
    output logic             serial_out
);

    import uart_io_pkg::*;

    logic [DATA_BITS-1:0] tx_data;
    logic                 tx_valid;
    logic                 tx_ready;
    logic [DATA_BITS-1:0] rx_data;
    logic                 rx_valid;

    logic [DATA_BITS-1:0] rx_byte;
    logic                 rx_full;
    logic                 rx_overrun;
    logic                 rx_pop;
    logic [31:0]          status_word;
    logic [31:0]          rd_word;

    // ------------------------------------------------------------
    // Transmit path
    // ------------------------------------------------------------
    // No back-pressure to the CPU, so a write while busy is simply lost
    assign tx_valid = wr_en && (addr == TX_DATA_ADDR);
    assign tx_data  = wr_data[DATA_BITS-1:0];

    uart_tx tx_i (
        .Clock      (Clock),
        .arst_n     (arst_n),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .serial_out (serial_out)
    );

    // ------------------------------------------------------------
    // Receive path and holding register
    // ------------------------------------------------------------
    uart_rx rx_i (
        .Clock     (Clock),
        .arst_n    (arst_n),
        .serial_in (serial_in),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid)
    );

    assign rx_pop = rd_en && (addr == RX_DATA_ADDR);

    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rx_full    <= 1'b0;
            rx_overrun <= 1'b0;
        end
        else if (rx_valid)
        begin
            // Overrun only if the old byte was never read
            rx_full    <= 1'b1;
            rx_overrun <= rx_full && !rx_pop;
        end
        else if (rx_pop)
        begin
            rx_full    <= 1'b0;
            rx_overrun <= 1'b0;
        end
    end

    // Newest byte always wins
    always_ff @(posedge Clock)
    begin
        if (rx_valid)
            rx_byte <= rx_data;
    end

    // ------------------------------------------------------------
    // Read data mux and output register
    // ------------------------------------------------------------
    always_comb
    begin
        status_word                  = '0;
        status_word[STAT_TX_READY]   = tx_ready;
        status_word[STAT_RX_VALID]   = rx_full;
        status_word[STAT_RX_OVERRUN] = rx_overrun;

        case (addr)
            STATUS_ADDR:  rd_word = status_word;
            RX_DATA_ADDR: rd_word = {{(32 - DATA_BITS){1'b0}}, rx_byte};
            default:      rd_word = '0;
        endcase
    end

    // Holds between reads
    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
            rd_data <= '0;
        else if (rd_en)
            rd_data <= rd_word;
    end

endmodule

`default_nettype wire

// ==== verilog/uart_io_pkg.sv ====
// UART I/O package with the register map, status bit positions and 8N1 frame timing
`default_nettype none

package uart_io_pkg;

    // ------------------------------------------------------------
    // CPU register map
    // ------------------------------------------------------------
    localparam logic [31:0] STATUS_ADDR  = 32'h8000_0000;
    localparam logic [31:0] RX_DATA_ADDR = 32'h8000_0004;
    localparam logic [31:0] TX_DATA_ADDR = 32'h8000_0008;

    // Bit positions inside the status word
    localparam int STAT_TX_READY   = 0;
    localparam int STAT_RX_VALID   = 1;
    localparam int STAT_RX_OVERRUN = 2;

    // ------------------------------------------------------------
    // Serial frame timing
    // ------------------------------------------------------------
    // Kept small so a frame is only 80 clocks in simulation
    localparam int CLOCKS_PER_BIT = 8;

    // Receiver samples here, counted from the start edge
    localparam int HALF_BIT = CLOCKS_PER_BIT / 2;

    // 8N1 framing with one start bit, eight data bits and one stop bit
    localparam int DATA_BITS = 8;

    // Counter widths
    localparam int BIT_CNT_W = $clog2(CLOCKS_PER_BIT);
    localparam int BIT_IDX_W = $clog2(DATA_BITS);

endpackage

`default_nettype wire

// ==== verilog/uart_rx.sv ====
// UART receiver that synchronises the serial input and recovers 8N1 bytes
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  wire logic                             Clock,
    input  wire logic                             arst_n,
    input  wire logic                             serial_in,
    output logic [uart_io_pkg::DATA_BITS-1:0]     rx_data,
    output logic                                  rx_valid
);

    import uart_io_pkg::*;

    enum logic [1:0] {IDLE, START, DATA, STOP} state;

    logic [1:0]           sync_ff;
    logic                 rx_s;
    logic                 rx_prev;
    logic                 falling;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [BIT_IDX_W-1:0] bit_idx;
    logic                 half_done;
    logic                 bit_done;

    // ------------------------------------------------------------
    // Input synchroniser and edge detect
    // ------------------------------------------------------------
    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sync_ff <= 2'b11;
            rx_prev <= 1'b1;
        end
        else
        begin
            sync_ff <= {sync_ff[0], serial_in};
            rx_prev <= rx_s;
        end
    end

    assign rx_s      = sync_ff[1];
    assign falling   = rx_prev && !rx_s;
    assign half_done = (bit_cnt == BIT_CNT_W'(HALF_BIT - 1));
    assign bit_done  = (bit_cnt == BIT_CNT_W'(CLOCKS_PER_BIT - 1));

    // ------------------------------------------------------------
    // Frame recovery
    // ------------------------------------------------------------
    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            bit_cnt  <= bit_done ? '0 : bit_cnt + 1'b1;
            case (state)
                IDLE:
                begin
                    bit_cnt <= '0;
                    if (falling)
                        state <= START;
                end
                START:
                    // Recheck at mid start bit; a glitch sends us back to idle
                    if (half_done)
                    begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? IDLE : DATA;
                    end
                DATA:
                    if (bit_done)
                    begin
                        if (bit_idx == BIT_IDX_W'(DATA_BITS - 1))
                            state <= STOP;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                default:
                    if (bit_done)
                    begin
                        // Framing error drops the byte silently
                        rx_valid <= rx_s;
                        state    <= IDLE;
                    end
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge Clock)
    begin
        if (state == DATA && bit_done)
            rx_data <= {rx_s, rx_data[DATA_BITS-1:1]};
    end

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
// UART transmitter that serialises one byte per valid/ready transfer into an 8N1 frame
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  wire logic                             Clock,
    input  wire logic                             arst_n,
    input  wire logic [uart_io_pkg::DATA_BITS-1:0] tx_data,
    input  wire logic                             tx_valid,
    output logic                                  tx_ready,
    output logic                                  serial_out
);

    import uart_io_pkg::*;

    enum logic [1:0] {IDLE, START, DATA, STOP} state;

    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [BIT_IDX_W-1:0] bit_idx;
    logic [DATA_BITS-1:0] shift_reg;
    logic                 bit_done;

    // Last clock of the current bit time
    assign bit_done = (bit_cnt == BIT_CNT_W'(CLOCKS_PER_BIT - 1));

    // Only accept a byte between frames
    assign tx_ready = (state == IDLE);

    // ------------------------------------------------------------
    // Frame sequencer
    // ------------------------------------------------------------
    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= IDLE;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            serial_out <= 1'b1;
        end
        else
        begin
            bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
            case (state)
                IDLE:
                begin
                    bit_cnt <= '0;
                    if (tx_valid)
                    begin
                        state      <= START;
                        serial_out <= 1'b0;
                    end
                end
                START:
                    if (bit_done)
                    begin
                        state      <= DATA;
                        bit_idx    <= '0;
                        serial_out <= shift_reg[0];
                    end
                DATA:
                    if (bit_done)
                    begin
                        if (bit_idx == BIT_IDX_W'(DATA_BITS - 1))
                        begin
                            state      <= STOP;
                            serial_out <= 1'b1;
                        end
                        else
                        begin
                            bit_idx    <= bit_idx + 1'b1;
                            // Next bit is already at position 1 before the shift
                            serial_out <= shift_reg[1];
                        end
                    end
                default:
                    if (bit_done)
                        state <= IDLE;
            endcase
        end
    end

    // LSB first, so shift right once per data bit
    always_ff @(posedge Clock)
    begin
        if (tx_valid && tx_ready)
            shift_reg <= tx_data;
        else if (state == DATA && bit_done)
            shift_reg <= {1'b0, shift_reg[DATA_BITS-1:1]};
    end

endmodule

`default_nettype wire
